// File: src/ssa_pkg.sv
`default_nettype none

package ssa_pkg;

    // router shape
    localparam int P  = 5;   // ports
    localparam int V  = 2;   // vcs per port
    localparam int PW = 3;   // port number width
    localparam int FW = 32;  // flit width

    // port numbers
    localparam logic [PW-1:0] PORT_LOCAL = PW'(0);
    localparam logic [PW-1:0] PORT_EAST  = PW'(1);
    localparam logic [PW-1:0] PORT_NORTH = PW'(2);
    localparam logic [PW-1:0] PORT_WEST  = PW'(3);
    localparam logic [PW-1:0] PORT_SOUTH = PW'(4);
    localparam logic [PW-1:0] PORT_NONE  = PW'(P);  // no straight port

    // flit layout, payload below the destination field
    localparam int HDR_BIT  = 31;
    localparam int TAIL_BIT = 30;
    localparam int VC_LSB   = 28;  // one-hot vc, V bits
    localparam int DST_LSB  = 25;  // header destination, PW bits

    // output port lying in the same direction as the input port
    function automatic logic [PW-1:0] straight_port(input int port);
        logic [PW-1:0] sp;
        case (port)
            int'(PORT_EAST):  sp = PORT_WEST;
            int'(PORT_WEST):  sp = PORT_EAST;
            int'(PORT_NORTH): sp = PORT_SOUTH;
            int'(PORT_SOUTH): sp = PORT_NORTH;
            default:          sp = PORT_NONE;  // local has no opposite
        endcase
        return sp;
    endfunction

endpackage

`default_nettype wire

// File: src/ssa_hdr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ssa_hdr_decode (
    input  logic                   flit_wr_i,
    input  logic [ssa_pkg::FW-1:0] flit_i,
    output logic                   hdr_o,
    output logic                   tail_o,
    output logic                   single_flit_o,
    output logic [ssa_pkg::PW-1:0] hdr_dest_o,
    output logic [ssa_pkg::V-1:0]  vc_wr_o
);

    logic [ssa_pkg::V-1:0] vc_field;

    // flag bits sit at the top of every flit
    assign hdr_o  = flit_i[ssa_pkg::HDR_BIT];
    assign tail_o = flit_i[ssa_pkg::TAIL_BIT];

    // min packet size is 1, so hdr and tail together mean a lone flit
    assign single_flit_o = flit_i[ssa_pkg::HDR_BIT] & flit_i[ssa_pkg::TAIL_BIT];

    // only valid on header flits, body flits carry payload here
    assign hdr_dest_o = flit_i[ssa_pkg::DST_LSB +: ssa_pkg::PW];

    assign vc_field = flit_i[ssa_pkg::VC_LSB +: ssa_pkg::V];  // one-hot

    // one write strobe per vc
    always_comb begin
        for (int v = 0; v < ssa_pkg::V; v++) begin
            vc_wr_o[v] = flit_wr_i & vc_field[v];
        end
    end

endmodule

`default_nettype wire

// File: src/ssa_vc_decide.sv
`timescale 1ns/1ps
`default_nettype none

module ssa_vc_decide #(
    parameter int VC_IDX = 0
) (
    input  logic [ssa_pkg::PW-1:0] straight_port_i,
    input  logic                   vc_wr_i,
    input  logic                   hdr_i,
    input  logic                   tail_i,
    input  logic                   single_flit_i,
    input  logic [ssa_pkg::PW-1:0] hdr_dest_i,
    input  logic                   ovc_granted_i,       // straight output port
    input  logic                   iport_sw_granted_i,  // own input port
    input  logic                   ovc_avail_i,
    input  logic                   ovc_full_i,
    input  logic                   ivc_req_i,
    input  logic                   ivc_ovc_assigned_i,
    input  logic [ssa_pkg::V-1:0]  ivc_assigned_ovc_i,
    input  logic [ssa_pkg::PW-1:0] ivc_dest_i,
    output logic                   sw_grant_o,
    output logic                   ovc_grant_o,
    output logic                   ivc_reset_o,
    output logic                   ovc_alloc_o,
    output logic                   ovc_release_o
);

    logic has_straight;
    logic held_ovc_ready;
    logic ovc_ready;
    logic permitted;
    logic fire;
    logic hdr_to_straight;
    logic sw_cond;
    logic ovc_cond;
    logic reset_cond;

    assign has_straight = (straight_port_i != ssa_pkg::PORT_NONE);

    // a held ovc must be ours in the straight port and have room
    assign held_ovc_ready = (ivc_dest_i == straight_port_i)
                          & ivc_assigned_ovc_i[VC_IDX]
                          & ~ovc_full_i;

    assign ovc_ready = ivc_ovc_assigned_i ? held_ovc_ready : ovc_avail_i;

    // nobody else may use the straight port or this input port now
    assign permitted = has_straight
                     & ~ivc_req_i
                     & ~ovc_granted_i
                     & ~iport_sw_granted_i
                     & ovc_ready;

    assign fire = permitted & vc_wr_i;

    // incoming header heading straight through
    assign hdr_to_straight = (hdr_dest_i == straight_port_i);

    // headers only pass when going straight, body and tail always
    assign sw_cond  = ~hdr_i | hdr_to_straight;
    assign ovc_cond = hdr_i & hdr_to_straight;

    // a lone flit frees the ivc as soon as it moves
    assign reset_cond = single_flit_i ? sw_cond : tail_i;

    assign sw_grant_o  = fire & sw_cond;  // doubles as buffer decrease
    assign ovc_grant_o = fire & ovc_cond;
    assign ivc_reset_o = fire & reset_cond;

    // single flit packets never hold the ovc
    assign ovc_alloc_o   = ovc_grant_o & ~single_flit_i;
    assign ovc_release_o = ivc_reset_o & ~single_flit_i;

endmodule

`default_nettype wire

// File: src/ssa_port_route.sv
`timescale 1ns/1ps
`default_nettype none

module ssa_port_route (
    input  logic clk,
    input  logic reset_i,
    input  logic sw_grant_i       [ssa_pkg::P][ssa_pkg::V],  // by input port
    input  logic ovc_alloc_i      [ssa_pkg::P][ssa_pkg::V],
    input  logic ovc_release_i    [ssa_pkg::P][ssa_pkg::V],
    output logic ovc_allocated_o  [ssa_pkg::P][ssa_pkg::V],  // by output port
    output logic ovc_released_o   [ssa_pkg::P][ssa_pkg::V],
    output logic buff_space_dec_o [ssa_pkg::P][ssa_pkg::V],
    output logic ssa_flit_wr_o    [ssa_pkg::P]
);

    logic fwd_wr [ssa_pkg::P];  // any vc forwarded into this output

    for (genvar o = 0; o < ssa_pkg::P; o++) begin : g_out
        // the mapping is its own inverse, so this is the feeding input
        localparam logic [ssa_pkg::PW-1:0] SRC = ssa_pkg::straight_port(o);

        if (SRC == ssa_pkg::PORT_NONE) begin : g_none
            // nothing runs straight into the local port
            for (genvar v = 0; v < ssa_pkg::V; v++) begin : g_vc
                assign ovc_allocated_o[o][v]  = 1'b0;
                assign ovc_released_o[o][v]   = 1'b0;
                assign buff_space_dec_o[o][v] = 1'b0;
            end
            assign fwd_wr[o] = 1'b0;
        end else begin : g_map
            for (genvar v = 0; v < ssa_pkg::V; v++) begin : g_vc
                assign ovc_allocated_o[o][v]  = ovc_alloc_i[SRC][v];
                assign ovc_released_o[o][v]   = ovc_release_i[SRC][v];
                assign buff_space_dec_o[o][v] = sw_grant_i[SRC][v];  // one credit per flit
            end

            always_comb begin
                fwd_wr[o] = 1'b0;
                for (int v = 0; v < ssa_pkg::V; v++) begin
                    fwd_wr[o] = fwd_wr[o] | sw_grant_i[SRC][v];
                end
            end
        end

        // flit reaches the output one cycle after the bypass decision
        always_ff @(posedge clk) begin
            if (reset_i) begin
                ssa_flit_wr_o[o] <= 1'b0;
            end else begin
                ssa_flit_wr_o[o] <= fwd_wr[o];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/ssa_allocator.sv
`timescale 1ns/1ps
`default_nettype none

module ssa_allocator (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   flit_wr_i          [ssa_pkg::P],
    input  logic [ssa_pkg::FW-1:0] flit_i             [ssa_pkg::P],
    input  logic                   ovc_granted_i      [ssa_pkg::P],
    input  logic                   iport_sw_granted_i [ssa_pkg::P],
    input  logic                   ovc_avail_i        [ssa_pkg::P][ssa_pkg::V],
    input  logic                   ovc_full_i         [ssa_pkg::P][ssa_pkg::V],
    input  logic                   ivc_req_i          [ssa_pkg::P][ssa_pkg::V],
    input  logic                   ivc_ovc_assigned_i [ssa_pkg::P][ssa_pkg::V],
    input  logic [ssa_pkg::V-1:0]  ivc_assigned_ovc_i [ssa_pkg::P][ssa_pkg::V],
    input  logic [ssa_pkg::PW-1:0] ivc_dest_i         [ssa_pkg::P][ssa_pkg::V],
    output logic                   ivc_sw_grant_o     [ssa_pkg::P][ssa_pkg::V],
    output logic                   ivc_ovc_grant_o    [ssa_pkg::P][ssa_pkg::V],
    output logic                   ivc_reset_o        [ssa_pkg::P][ssa_pkg::V],
    output logic                   ivc_single_flit_o  [ssa_pkg::P][ssa_pkg::V],
    output logic                   ovc_allocated_o    [ssa_pkg::P][ssa_pkg::V],
    output logic                   ovc_released_o     [ssa_pkg::P][ssa_pkg::V],
    output logic                   buff_space_dec_o   [ssa_pkg::P][ssa_pkg::V],
    output logic                   ssa_flit_wr_o      [ssa_pkg::P]
);

    // decoded flit fields, per input port
    logic                   hdr         [ssa_pkg::P];
    logic                   tail        [ssa_pkg::P];
    logic                   single_flit [ssa_pkg::P];
    logic [ssa_pkg::PW-1:0] hdr_dest    [ssa_pkg::P];
    logic [ssa_pkg::V-1:0]  vc_wr       [ssa_pkg::P];

    // input-side decisions
    logic sw_grant    [ssa_pkg::P][ssa_pkg::V];
    logic ovc_alloc   [ssa_pkg::P][ssa_pkg::V];
    logic ovc_release [ssa_pkg::P][ssa_pkg::V];

    for (genvar p = 0; p < ssa_pkg::P; p++) begin : g_port
        localparam logic [ssa_pkg::PW-1:0] SP = ssa_pkg::straight_port(p);

        ssa_hdr_decode i_hdr_decode (
            .flit_wr_i     (flit_wr_i[p]),
            .flit_i        (flit_i[p]),
            .hdr_o         (hdr[p]),
            .tail_o        (tail[p]),
            .single_flit_o (single_flit[p]),
            .hdr_dest_o    (hdr_dest[p]),
            .vc_wr_o       (vc_wr[p])
        );

        for (genvar v = 0; v < ssa_pkg::V; v++) begin : g_vc
            // flagged on the vc that carried the lone flit
            assign ivc_single_flit_o[p][v] = single_flit[p] & vc_wr[p][v];
            assign ivc_sw_grant_o[p][v]    = sw_grant[p][v];

            if (SP == ssa_pkg::PORT_NONE) begin : g_off
                // local port never bypasses
                assign sw_grant[p][v]        = 1'b0;
                assign ivc_ovc_grant_o[p][v] = 1'b0;
                assign ivc_reset_o[p][v]     = 1'b0;
                assign ovc_alloc[p][v]       = 1'b0;
                assign ovc_release[p][v]     = 1'b0;
            end else begin : g_on
                ssa_vc_decide #(
                    .VC_IDX (v)
                ) i_vc_decide (
                    .straight_port_i    (SP),
                    .vc_wr_i            (vc_wr[p][v]),
                    .hdr_i              (hdr[p]),
                    .tail_i             (tail[p]),
                    .single_flit_i      (single_flit[p]),
                    .hdr_dest_i         (hdr_dest[p]),
                    .ovc_granted_i      (ovc_granted_i[SP]),
                    .iport_sw_granted_i (iport_sw_granted_i[p]),
                    .ovc_avail_i        (ovc_avail_i[SP][v]),  // same vc index downstream
                    .ovc_full_i         (ovc_full_i[SP][v]),
                    .ivc_req_i          (ivc_req_i[p][v]),
                    .ivc_ovc_assigned_i (ivc_ovc_assigned_i[p][v]),
                    .ivc_assigned_ovc_i (ivc_assigned_ovc_i[p][v]),
                    .ivc_dest_i         (ivc_dest_i[p][v]),
                    .sw_grant_o         (sw_grant[p][v]),
                    .ovc_grant_o        (ivc_ovc_grant_o[p][v]),
                    .ivc_reset_o        (ivc_reset_o[p][v]),
                    .ovc_alloc_o        (ovc_alloc[p][v]),
                    .ovc_release_o      (ovc_release[p][v])
                );
            end
        end
    end

    // output side view and the registered write strobe
    ssa_port_route i_port_route (
        .clk              (clk),
        .reset_i          (reset_i),
        .sw_grant_i       (sw_grant),
        .ovc_alloc_i      (ovc_alloc),
        .ovc_release_i    (ovc_release),
        .ovc_allocated_o  (ovc_allocated_o),
        .ovc_released_o   (ovc_released_o),
        .buff_space_dec_o (buff_space_dec_o),
        .ssa_flit_wr_o    (ssa_flit_wr_o)
    );

endmodule

`default_nettype wire

// File: tb/ssa_ref_model.svh
`ifndef SSA_REF_MODEL_SVH
`define SSA_REF_MODEL_SVH

// expected dut outputs, rebuilt every cycle from the driven inputs
logic exp_sw_grant  [ssa_pkg::P][ssa_pkg::V];
logic exp_ovc_grant [ssa_pkg::P][ssa_pkg::V];
logic exp_ivc_reset [ssa_pkg::P][ssa_pkg::V];
logic exp_single    [ssa_pkg::P][ssa_pkg::V];
logic exp_allocated [ssa_pkg::P][ssa_pkg::V];  // by output port
logic exp_released  [ssa_pkg::P][ssa_pkg::V];
logic exp_buff_dec  [ssa_pkg::P][ssa_pkg::V];
logic exp_fwd       [ssa_pkg::P];              // before the register

logic [15:0] lfsr_state = 16'd38;

// galois lfsr, taps 16 14 13 11
function automatic logic rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[15:1]};
    if (lsb) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return lsb;
endfunction

// n fresh bits, one lfsr step each
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], rand_bit()};
    end
    return r;
endfunction

// set about one time in four
function automatic logic rare_bit();
    logic [31:0] r;
    r = rand_bits(2);
    return r[0] & r[1];
endfunction

// opposite direction, -1 for the local port
function automatic int opposite_port(input int port);
    if (port == int'(ssa_pkg::PORT_EAST)) return int'(ssa_pkg::PORT_WEST);
    if (port == int'(ssa_pkg::PORT_WEST)) return int'(ssa_pkg::PORT_EAST);
    if (port == int'(ssa_pkg::PORT_NORTH)) return int'(ssa_pkg::PORT_SOUTH);
    if (port == int'(ssa_pkg::PORT_SOUTH)) return int'(ssa_pkg::PORT_NORTH);
    return -1;
endfunction

// dst only lands in header flits, body flits keep the payload bits there
function automatic logic [ssa_pkg::FW-1:0] make_flit(input logic hdr, input logic tail,
        input int vc, input logic [ssa_pkg::PW-1:0] dst,
        input logic [ssa_pkg::FW-1:0] payload);
    logic [ssa_pkg::FW-1:0] f;
    f = payload;
    f[ssa_pkg::HDR_BIT] = hdr;
    f[ssa_pkg::TAIL_BIT] = tail;
    f[ssa_pkg::VC_LSB +: ssa_pkg::V] = '0;
    f[ssa_pkg::VC_LSB + vc] = 1'b1;
    if (hdr) begin
        f[ssa_pkg::DST_LSB +: ssa_pkg::PW] = dst;
    end
    return f;
endfunction

function automatic void compute_expected();
    int s;
    logic wr_here;
    logic is_hdr;
    logic lone;
    logic straight_hdr;
    logic ready;
    logic moves;
    logic [ssa_pkg::PW-1:0] dst;
    for (int o = 0; o < ssa_pkg::P; o++) begin
        exp_fwd[o] = 1'b0;
        for (int v = 0; v < ssa_pkg::V; v++) begin
            exp_allocated[o][v] = 1'b0;
            exp_released[o][v] = 1'b0;
            exp_buff_dec[o][v] = 1'b0;
        end
    end
    for (int p = 0; p < ssa_pkg::P; p++) begin
        s = opposite_port(p);
        is_hdr = flit[p][ssa_pkg::HDR_BIT];
        lone = is_hdr & flit[p][ssa_pkg::TAIL_BIT];
        dst = flit[p][ssa_pkg::DST_LSB +: ssa_pkg::PW];
        straight_hdr = is_hdr && s >= 0 && int'(dst) == s;
        for (int v = 0; v < ssa_pkg::V; v++) begin
            wr_here = flit_wr[p] & flit[p][ssa_pkg::VC_LSB + v];
            exp_single[p][v] = wr_here & lone;
            exp_sw_grant[p][v] = 1'b0;
            exp_ovc_grant[p][v] = 1'b0;
            exp_ivc_reset[p][v] = 1'b0;
            if (wr_here && s >= 0) begin
                // a held ovc overrides the availability flag
                if (ivc_ovc_assigned[p][v]) begin
                    ready = int'(ivc_dest[p][v]) == s && ivc_assigned_ovc[p][v][v]
                            && !ovc_full[s][v];
                end else begin
                    ready = ovc_avail[s][v];
                end
                if (ready && !ivc_req[p][v] && !ovc_granted[s] && !iport_sw_granted[p]) begin
                    moves = !is_hdr || straight_hdr;
                    exp_sw_grant[p][v] = moves;
                    exp_ovc_grant[p][v] = straight_hdr;
                    exp_ivc_reset[p][v] = lone ? moves : flit[p][ssa_pkg::TAIL_BIT];
                    exp_buff_dec[s][v] = moves;
                    exp_fwd[s] = exp_fwd[s] | moves;
                    if (!lone) begin
                        exp_allocated[s][v] = straight_hdr;
                        exp_released[s][v] = exp_ivc_reset[p][v];
                    end
                end
            end
        end
    end
endfunction

`endif

// File: tb/ssa_allocator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ssa_allocator_tb;

    logic clk = 1'b0;
    logic reset_i;

    logic                   flit_wr          [ssa_pkg::P];
    logic [ssa_pkg::FW-1:0] flit             [ssa_pkg::P];
    logic                   ovc_granted      [ssa_pkg::P];
    logic                   iport_sw_granted [ssa_pkg::P];
    logic                   ovc_avail        [ssa_pkg::P][ssa_pkg::V];
    logic                   ovc_full         [ssa_pkg::P][ssa_pkg::V];
    logic                   ivc_req          [ssa_pkg::P][ssa_pkg::V];
    logic                   ivc_ovc_assigned [ssa_pkg::P][ssa_pkg::V];
    logic [ssa_pkg::V-1:0]  ivc_assigned_ovc [ssa_pkg::P][ssa_pkg::V];
    logic [ssa_pkg::PW-1:0] ivc_dest         [ssa_pkg::P][ssa_pkg::V];

    logic ivc_sw_grant    [ssa_pkg::P][ssa_pkg::V];
    logic ivc_ovc_grant   [ssa_pkg::P][ssa_pkg::V];
    logic ivc_reset       [ssa_pkg::P][ssa_pkg::V];
    logic ivc_single_flit [ssa_pkg::P][ssa_pkg::V];
    logic ovc_allocated   [ssa_pkg::P][ssa_pkg::V];
    logic ovc_released    [ssa_pkg::P][ssa_pkg::V];
    logic buff_space_dec  [ssa_pkg::P][ssa_pkg::V];
    logic ssa_flit_wr     [ssa_pkg::P];

    logic  fwd_prev [ssa_pkg::P];  // expected register contents
    logic  any_flit_wr;
    int    latency;
    string test_name = "reset";
    int    error_count = 0;
    int    check_count = 0;

    `include "ssa_ref_model.svh"

    always #2 clk = ~clk;  // 4 ns period

    ssa_allocator i_ssa_allocator (
        .clk                (clk),
        .reset_i            (reset_i),
        .flit_wr_i          (flit_wr),
        .flit_i             (flit),
        .ovc_granted_i      (ovc_granted),
        .iport_sw_granted_i (iport_sw_granted),
        .ovc_avail_i        (ovc_avail),
        .ovc_full_i         (ovc_full),
        .ivc_req_i          (ivc_req),
        .ivc_ovc_assigned_i (ivc_ovc_assigned),
        .ivc_assigned_ovc_i (ivc_assigned_ovc),
        .ivc_dest_i         (ivc_dest),
        .ivc_sw_grant_o     (ivc_sw_grant),
        .ivc_ovc_grant_o    (ivc_ovc_grant),
        .ivc_reset_o        (ivc_reset),
        .ivc_single_flit_o  (ivc_single_flit),
        .ovc_allocated_o    (ovc_allocated),
        .ovc_released_o     (ovc_released),
        .buff_space_dec_o   (buff_space_dec),
        .ssa_flit_wr_o      (ssa_flit_wr)
    );

    always_comb begin
        any_flit_wr = 1'b0;
        for (int o = 0; o < ssa_pkg::P; o++) begin
            any_flit_wr = any_flit_wr | ssa_flit_wr[o];
        end
    end

    // register must come out of reset cleared
    reset_clears_flit_wr: assert property (@(posedge clk) reset_i |=> !any_flit_wr)
        else begin
            error_count++;
            $display("Error %s: ssa_flit_wr_o after reset expected 0 actual %0b",
                     test_name, any_flit_wr);
        end

    task automatic check_bit(input string sig, input int p, input int v,
                             input logic exp, input logic act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("Error %s: %s[%0d][%0d] expected %0b actual %0b",
                     test_name, sig, p, v, exp, act);
        end
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        check_count++;
        assert (act == exp) else begin
            error_count++;
            $display("Error %s: %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (reset_i) begin
            for (int o = 0; o < ssa_pkg::P; o++) begin
                check_bit("ssa_flit_wr_o", o, 0, 1'b0, ssa_flit_wr[o]);
                fwd_prev[o] = 1'b0;
            end
        end else begin
            compute_expected();
            for (int p = 0; p < ssa_pkg::P; p++) begin
                for (int v = 0; v < ssa_pkg::V; v++) begin
                    check_bit("ivc_sw_grant_o", p, v, exp_sw_grant[p][v], ivc_sw_grant[p][v]);
                    check_bit("ivc_ovc_grant_o", p, v, exp_ovc_grant[p][v], ivc_ovc_grant[p][v]);
                    check_bit("ivc_reset_o", p, v, exp_ivc_reset[p][v], ivc_reset[p][v]);
                    check_bit("ivc_single_flit_o", p, v, exp_single[p][v], ivc_single_flit[p][v]);
                    check_bit("ovc_allocated_o", p, v, exp_allocated[p][v], ovc_allocated[p][v]);
                    check_bit("ovc_released_o", p, v, exp_released[p][v], ovc_released[p][v]);
                    check_bit("buff_space_dec_o", p, v, exp_buff_dec[p][v], buff_space_dec[p][v]);
                end
            end
            for (int o = 0; o < ssa_pkg::P; o++) begin
                check_bit("ssa_flit_wr_o", o, 0, fwd_prev[o], ssa_flit_wr[o]);
                fwd_prev[o] = exp_fwd[o];
            end
        end
    end

    // idle router with every output vc free
    task automatic default_inputs();
        for (int p = 0; p < ssa_pkg::P; p++) begin
            flit_wr[p] <= 1'b0;
            flit[p] <= '0;
            ovc_granted[p] <= 1'b0;
            iport_sw_granted[p] <= 1'b0;
            for (int v = 0; v < ssa_pkg::V; v++) begin
                ovc_avail[p][v] <= 1'b1;
                ovc_full[p][v] <= 1'b0;
                ivc_req[p][v] <= 1'b0;
                ivc_ovc_assigned[p][v] <= 1'b0;
                ivc_assigned_ovc[p][v] <= '0;
                ivc_dest[p][v] <= '0;
            end
        end
    endtask

    task automatic begin_cycle();
        @(posedge clk);
        default_inputs();
    endtask

    task automatic wait_flit_wr(input int port, input int max_cycles, output int cycles);
        cycles = -1;
        for (int i = 1; i <= max_cycles && cycles < 0; i++) begin
            @(negedge clk);
            if (ssa_flit_wr[port]) begin
                cycles = i;
            end
        end
        if (cycles < 0) begin
            error_count++;
            $display("timeout in %s: ssa_flit_wr_o[%0d] did not rise within %0d cycles",
                     test_name, port, max_cycles);
        end
    endtask

    task automatic send_straight_header();
        test_name = "straight_header";
        begin_cycle();
        flit_wr[ssa_pkg::PORT_EAST] <= 1'b1;
        flit[ssa_pkg::PORT_EAST] <= make_flit(1'b1, 1'b0, 0, ssa_pkg::PORT_WEST, 32'h0000_1234);
        @(negedge clk);
        check_bit("ivc_ovc_grant_o", ssa_pkg::PORT_EAST, 0, 1'b1,
                  ivc_ovc_grant[ssa_pkg::PORT_EAST][0]);
        check_bit("ivc_sw_grant_o", ssa_pkg::PORT_EAST, 0, 1'b1,
                  ivc_sw_grant[ssa_pkg::PORT_EAST][0]);
        check_bit("ovc_allocated_o", ssa_pkg::PORT_WEST, 0, 1'b1, ovc_allocated[ssa_pkg::PORT_WEST][0]);
        check_bit("buff_space_dec_o", ssa_pkg::PORT_WEST, 0, 1'b1,
                  buff_space_dec[ssa_pkg::PORT_WEST][0]);
        begin_cycle();
        wait_flit_wr(ssa_pkg::PORT_WEST, 4, latency);
        check_value("ssa_flit_wr_o latency", 1, latency);
    endtask

    task automatic try_blockers();
        test_name = "blocking";
        for (int k = 0; k < 4; k++) begin
            begin_cycle();
            flit_wr[ssa_pkg::PORT_EAST] <= 1'b1;
            flit[ssa_pkg::PORT_EAST] <= make_flit(1'b1, 1'b0, 0, ssa_pkg::PORT_WEST, '0);
            case (k)
                0: ovc_granted[ssa_pkg::PORT_WEST] <= 1'b1;
                1: iport_sw_granted[ssa_pkg::PORT_EAST] <= 1'b1;
                2: ivc_req[ssa_pkg::PORT_EAST][0] <= 1'b1;
                default: ovc_avail[ssa_pkg::PORT_WEST][0] <= 1'b0;
            endcase
            @(negedge clk);
            check_bit("ivc_sw_grant_o", ssa_pkg::PORT_EAST, 0, 1'b0,
                      ivc_sw_grant[ssa_pkg::PORT_EAST][0]);
        end
    endtask

    task automatic send_turning_flits();
        test_name = "turning";
        begin_cycle();
        flit_wr[ssa_pkg::PORT_EAST] <= 1'b1;
        flit[ssa_pkg::PORT_EAST] <= make_flit(1'b1, 1'b0, 1, ssa_pkg::PORT_NORTH, '0);
        flit_wr[ssa_pkg::PORT_LOCAL] <= 1'b1;  // local never bypasses
        flit[ssa_pkg::PORT_LOCAL] <= make_flit(1'b1, 1'b0, 0, ssa_pkg::PORT_EAST, '0);
        @(negedge clk);
        check_bit("ivc_sw_grant_o", ssa_pkg::PORT_EAST, 1, 1'b0,
                  ivc_sw_grant[ssa_pkg::PORT_EAST][1]);
        check_bit("ivc_ovc_grant_o", ssa_pkg::PORT_LOCAL, 0, 1'b0,
                  ivc_ovc_grant[ssa_pkg::PORT_LOCAL][0]);
    endtask

    // east vc1 already owns west ovc1 until the last three cycles spoil that
    task automatic stream_held_ovc();
        test_name = "held_ovc";
        for (int k = 0; k < 5; k++) begin
            begin_cycle();
            ivc_ovc_assigned[ssa_pkg::PORT_EAST][1] <= 1'b1;
            ivc_assigned_ovc[ssa_pkg::PORT_EAST][1] <= 2'b10;
            ivc_dest[ssa_pkg::PORT_EAST][1] <= ssa_pkg::PORT_WEST;
            ovc_avail[ssa_pkg::PORT_WEST][1] <= 1'b0;  // ignored while held
            flit_wr[ssa_pkg::PORT_EAST] <= 1'b1;
            flit[ssa_pkg::PORT_EAST] <= make_flit(1'b0, k != 0, 1, '0, 32'h00AB_CDEF);
            case (k)
                2: ovc_full[ssa_pkg::PORT_WEST][1] <= 1'b1;
                3: ivc_assigned_ovc[ssa_pkg::PORT_EAST][1] <= 2'b01;
                4: ivc_dest[ssa_pkg::PORT_EAST][1] <= ssa_pkg::PORT_NORTH;
                default: ;
            endcase
            @(negedge clk);
        end
    endtask

    task automatic send_single_flits();
        test_name = "single_flit";
        begin_cycle();
        flit_wr[ssa_pkg::PORT_NORTH] <= 1'b1;
        flit[ssa_pkg::PORT_NORTH] <= make_flit(1'b1, 1'b1, 0, ssa_pkg::PORT_SOUTH, '0);
        flit_wr[ssa_pkg::PORT_SOUTH] <= 1'b1;
        flit[ssa_pkg::PORT_SOUTH] <= make_flit(1'b1, 1'b1, 1, ssa_pkg::PORT_NORTH, '0);
        @(negedge clk);
        check_bit("ivc_reset_o", ssa_pkg::PORT_NORTH, 0, 1'b1, ivc_reset[ssa_pkg::PORT_NORTH][0]);
        check_bit("ovc_allocated_o", ssa_pkg::PORT_SOUTH, 0, 1'b0,
                  ovc_allocated[ssa_pkg::PORT_SOUTH][0]);
    endtask

    task automatic drive_random_cycle();
        int s;
        int vc;
        logic hdr;
        logic tail;
        logic [31:0] r;
        logic [ssa_pkg::PW-1:0] dst;
        begin_cycle();
        for (int p = 0; p < ssa_pkg::P; p++) begin
            s = opposite_port(p);
            r = rand_bits(ssa_pkg::PW);
            dst = r[ssa_pkg::PW-1:0];
            if (s >= 0 && rand_bit()) begin
                dst = s[ssa_pkg::PW-1:0];  // lean toward straight traffic
            end
            hdr = rand_bit();
            tail = rand_bit();
            vc = int'(rand_bit());
            r = rand_bits(32);
            flit_wr[p] <= rand_bit();
            flit[p] <= make_flit(hdr, tail, vc, dst, r);
            ovc_granted[p] <= rare_bit();
            iport_sw_granted[p] <= rare_bit();
            for (int v = 0; v < ssa_pkg::V; v++) begin
                ovc_avail[p][v] <= rand_bit();
                ovc_full[p][v] <= rare_bit();
                ivc_req[p][v] <= rare_bit();
                ivc_ovc_assigned[p][v] <= rand_bit();
                r = rand_bits(ssa_pkg::V);
                ivc_assigned_ovc[p][v] <= r[ssa_pkg::V-1:0];
                ivc_dest[p][v] <= rand_bit() ? dst : ssa_pkg::PORT_LOCAL;
            end
        end
    endtask

    initial begin
        reset_i <= 1'b1;
        default_inputs();
        // a straight header sits on east all through reset
        flit_wr[ssa_pkg::PORT_EAST] <= 1'b1;
        flit[ssa_pkg::PORT_EAST] <= make_flit(1'b1, 1'b0, 0, ssa_pkg::PORT_WEST, '0);
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        default_inputs();
        send_straight_header();
        try_blockers();
        send_turning_flits();
        stream_held_ovc();
        send_single_flits();
        test_name = "random";
        for (int c = 0; c < 200; c++) begin
            drive_random_cycle();
        end
        begin_cycle();
        @(negedge clk);  // last registered strobe
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+tb
src/ssa_pkg.sv
src/ssa_hdr_decode.sv
src/ssa_vc_decide.sv
src/ssa_port_route.sv
src/ssa_allocator.sv
tb/ssa_allocator_tb.sv

// File: Bender.yml
package:
  name: ssa_allocator

sources:
  # design, package first
  - files:
      - src/ssa_pkg.sv
      - src/ssa_hdr_decode.sv
      - src/ssa_vc_decide.sv
      - src/ssa_port_route.sv
      - src/ssa_allocator.sv

  # testbench, pulls in tb/ssa_ref_model.svh
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ssa_allocator_tb.sv
